/* verilog/apb_wbuf_pkg.sv */
`default_nettype none

package apb_wbuf_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////

	// Byte address, same on both sides
	localparam int ADDR_WIDTH = 16;

	// Upstream requester data
	localparam int UP_DATA_WIDTH = 64;

	// Register bank side
	localparam int TGT_DATA_WIDTH = 32;

	//////////////////////////////
	// APB bundles
	//////////////////////////////

	// Upstream requester outputs
	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [ADDR_WIDTH-1:0]    paddr;
		logic [UP_DATA_WIDTH-1:0] pwdata;
	} apb64_req_t;

	// Upstream completer outputs
	typedef struct packed {
		logic                     pready;
		logic [UP_DATA_WIDTH-1:0] prdata;
		logic                     pslverr;
	} apb64_rsp_t;

	// Downstream requester outputs
	typedef struct packed {
		logic                      psel;
		logic                      penable;
		logic                      pwrite;
		logic [ADDR_WIDTH-1:0]     paddr;
		logic [TGT_DATA_WIDTH-1:0] pwdata;
	} apb32_req_t;

	// Downstream completer outputs
	typedef struct packed {
		logic                      pready;
		logic [TGT_DATA_WIDTH-1:0] prdata;
		logic                      pslverr;
	} apb32_rsp_t;

	//////////////////////////////
	// Internal bundles
	//////////////////////////////

	// One buffered 64-bit write
	typedef struct packed {
		logic [ADDR_WIDTH-1:0]    addr;
		logic [UP_DATA_WIDTH-1:0] data;
	} wbuf_entry_t;

	// Read waiting on the splitter
	typedef struct packed {
		logic                  valid;
		logic [ADDR_WIDTH-1:0] addr;
	} rd_req_t;

	// Read answer, done is a single cycle pulse
	typedef struct packed {
		logic                      done;
		logic [TGT_DATA_WIDTH-1:0] data;
	} rd_rsp_t;

endpackage

`default_nettype wire

/* verilog/apb_wbuf_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_wbuf_fifo import apb_wbuf_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input wire logic        down,
	input wire logic        rst,
	input wire logic        push,
	input wire wbuf_entry_t push_entry,
	input wire logic        pop,
	output wbuf_entry_t     head,
	output logic            full,
	output logic            empty
);

	// Depth of one still needs one pointer bit
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	// Count has to reach FIFO_DEPTH itself
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	wbuf_entry_t      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;

	// Pointer step with wrap at the last slot
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Guard against overflow and underflow
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);

	// Show-ahead output
	assign head = mem[rd_ptr];

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge down) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	always_ff @(posedge down) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			// Simultaneous push and pop leaves count alone
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/apb_wbuf_upstream.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_wbuf_upstream import apb_wbuf_pkg::*; (
	input wire logic       down,
	input wire logic       rst,
	input wire apb64_req_t up_req,
	output apb64_rsp_t     up_rsp,
	input wire logic       fifo_full,
	output logic           push,
	output wbuf_entry_t    push_entry,
	output rd_req_t        rd_req,
	input wire rd_rsp_t    rd_rsp
);

	logic access;
	logic wr_access;
	logic rd_access;
	logic rd_finish;
	// Set once the current read got its answer
	logic rd_done;

	//////////////////////////////
	// Access phase decode
	//////////////////////////////

	assign access    = up_req.psel && up_req.penable;
	assign wr_access = access && up_req.pwrite;
	assign rd_access = access && !up_req.pwrite;

	// Writes go straight into the FIFO when there is room
	assign push            = wr_access && !fifo_full;
	assign push_entry.addr = up_req.paddr;
	assign push_entry.data = up_req.pwdata;

	// Read request held through the access phase
	assign rd_req.valid = rd_access && !rd_done;
	assign rd_req.addr  = up_req.paddr;

	// Splitter answer for the read in progress
	assign rd_finish = rd_access && rd_rsp.done;

	//////////////////////////////
	// One request per read
	//////////////////////////////

	always_ff @(posedge down) begin
		if (rst) begin
			rd_done <= 1'b0;
		end else if (!access) begin
			// Access phase over, arm for the next read
			rd_done <= 1'b0;
		end else if (rd_finish) begin
			rd_done <= 1'b1;
		end
	end

	//////////////////////////////
	// Upstream response
	//////////////////////////////

	always_comb begin
		up_rsp = '0;
		// Write acknowledge needs FIFO space only
		if (push) begin
			up_rsp.pready = 1'b1;
		end
		// Read data zero extended to the upstream width
		if (rd_finish) begin
			up_rsp.pready = 1'b1;
			up_rsp.prdata = {{(UP_DATA_WIDTH - TGT_DATA_WIDTH){1'b0}}, rd_rsp.data};
		end
		// No error path
		up_rsp.pslverr = 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/apb_wbuf_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_wbuf_splitter import apb_wbuf_pkg::*; (
	input wire logic        down,
	input wire logic        rst,
	input wire wbuf_entry_t head,
	input wire logic        empty,
	output logic            pop,
	input wire rd_req_t     rd_req,
	output rd_rsp_t         rd_rsp,
	output apb32_req_t      tgt_req,
	input wire apb32_rsp_t  tgt_rsp
);

	typedef enum logic [2:0] {
		IDLE,
		HI_SETUP,
		HI_ACCESS,
		LO_SETUP,
		LO_ACCESS,
		RD_SETUP,
		RD_ACCESS
	} state_t;

	state_t state;
	state_t state_next;

	// Second word of the pair
	logic [ADDR_WIDTH-1:0] lo_addr;

	assign lo_addr = head.addr + ADDR_WIDTH'(4);

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// Buffered writes always go first
				if (!empty) begin
					state_next = HI_SETUP;
				end else if (rd_req.valid) begin
					state_next = RD_SETUP;
				end
			end
			HI_SETUP: state_next = HI_ACCESS;
			HI_ACCESS: begin
				if (tgt_rsp.pready) begin
					state_next = LO_SETUP;
				end
			end
			LO_SETUP: state_next = LO_ACCESS;
			LO_ACCESS: begin
				if (tgt_rsp.pready) begin
					state_next = IDLE;
				end
			end
			RD_SETUP: state_next = RD_ACCESS;
			RD_ACCESS: begin
				if (tgt_rsp.pready) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge down) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// Downstream bus
	//////////////////////////////

	always_comb begin
		tgt_req = '0;
		case (state)
			// Upper half at the entry address
			HI_SETUP, HI_ACCESS: begin
				tgt_req.psel    = 1'b1;
				tgt_req.penable = (state == HI_ACCESS);
				tgt_req.pwrite  = 1'b1;
				tgt_req.paddr   = head.addr;
				tgt_req.pwdata  = head.data[UP_DATA_WIDTH-1 -: TGT_DATA_WIDTH];
			end
			// Lower half one word up
			LO_SETUP, LO_ACCESS: begin
				tgt_req.psel    = 1'b1;
				tgt_req.penable = (state == LO_ACCESS);
				tgt_req.pwrite  = 1'b1;
				tgt_req.paddr   = lo_addr;
				tgt_req.pwdata  = head.data[TGT_DATA_WIDTH-1:0];
			end
			// Single word read at the upstream address
			RD_SETUP, RD_ACCESS: begin
				tgt_req.psel    = 1'b1;
				tgt_req.penable = (state == RD_ACCESS);
				tgt_req.paddr   = rd_req.addr;
			end
			default: tgt_req = '0;
		endcase
	end

	//////////////////////////////
	// Strobes back upstream
	//////////////////////////////

	// Entry retired once the second word lands
	assign pop = (state == LO_ACCESS) && tgt_rsp.pready;

	// Read answer in the completing cycle
	assign rd_rsp.done = (state == RD_ACCESS) && tgt_rsp.pready;
	assign rd_rsp.data = tgt_rsp.prdata;

endmodule

`default_nettype wire

/* verilog/apb_reg_bank32.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_reg_bank32 import apb_wbuf_pkg::*; #(
	parameter int WAIT_CYCLES = 1,
	parameter int REG_WORDS   = 64
) (
	input wire logic       down,
	input wire logic       rst,
	input wire apb32_req_t tgt_req,
	output apb32_rsp_t     tgt_rsp
);

	// Word index bits taken just above the byte offset
	localparam int IDX_W = (REG_WORDS > 1) ? $clog2(REG_WORDS) : 1;
	// Wait counter must reach WAIT_CYCLES
	localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic [TGT_DATA_WIDTH-1:0] regs [REG_WORDS];
	logic [CNT_W-1:0]          wait_cnt;
	logic [IDX_W-1:0]          idx;
	logic                      access;
	logic                      ready;

	assign access = tgt_req.psel && tgt_req.penable;
	// Upper address bits ignored so the bank aliases
	assign idx    = tgt_req.paddr[2 +: IDX_W];
	// Ready after the programmed number of access cycles
	assign ready  = access && (wait_cnt == CNT_W'(WAIT_CYCLES));

	//////////////////////////////
	// Wait states
	//////////////////////////////

	always_ff @(posedge down) begin
		if (rst) begin
			wait_cnt <= '0;
		end else if (access && !ready) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			// Back to zero after each transfer
			wait_cnt <= '0;
		end
	end

	//////////////////////////////
	// Register file
	//////////////////////////////

	always_ff @(posedge down) begin
		if (rst) begin
			for (int i = 0; i < REG_WORDS; i++) begin
				regs[i] <= '0;
			end
		end else if (ready && tgt_req.pwrite) begin
			regs[idx] <= tgt_req.pwdata;
		end
	end

	// Response only in the ready cycle
	always_comb begin
		tgt_rsp = '0;
		tgt_rsp.pready = ready;
		if (ready && !tgt_req.pwrite) begin
			tgt_rsp.prdata = regs[idx];
		end
		tgt_rsp.pslverr = 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/apb_wbuf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_wbuf_top import apb_wbuf_pkg::*; #(
	parameter int FIFO_DEPTH  = 16,
	parameter int WAIT_CYCLES = 1,
	parameter int REG_WORDS   = 64
) (
	input wire logic       down,
	input wire logic       rst,
	input wire apb64_req_t up_req,
	output apb64_rsp_t     up_rsp
);

	// Upstream stage to FIFO
	logic        fifo_push;
	wbuf_entry_t push_entry;
	logic        fifo_full;

	// FIFO to splitter
	wbuf_entry_t fifo_head;
	logic        fifo_empty;
	logic        fifo_pop;

	// Read path between upstream stage and splitter
	rd_req_t rd_req;
	rd_rsp_t rd_rsp;

	// 32-bit target bus
	apb32_req_t tgt_req;
	apb32_rsp_t tgt_rsp;

	//////////////////////////////
	// 64-bit completer
	//////////////////////////////

	apb_wbuf_upstream i_upstream (
		.down       (down),
		.rst        (rst),
		.up_req     (up_req),
		.up_rsp     (up_rsp),
		.fifo_full  (fifo_full),
		.push       (fifo_push),
		.push_entry (push_entry),
		.rd_req     (rd_req),
		.rd_rsp     (rd_rsp)
	);

	// Write buffer
	apb_wbuf_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.down       (down),
		.rst        (rst),
		.push       (fifo_push),
		.push_entry (push_entry),
		.pop        (fifo_pop),
		.head       (fifo_head),
		.full       (fifo_full),
		.empty      (fifo_empty)
	);

	//////////////////////////////
	// 32-bit side
	//////////////////////////////

	apb_wbuf_splitter i_splitter (
		.down    (down),
		.rst     (rst),
		.head    (fifo_head),
		.empty   (fifo_empty),
		.pop     (fifo_pop),
		.rd_req  (rd_req),
		.rd_rsp  (rd_rsp),
		.tgt_req (tgt_req),
		.tgt_rsp (tgt_rsp)
	);

	// Target register bank
	apb_reg_bank32 #(
		.WAIT_CYCLES (WAIT_CYCLES),
		.REG_WORDS   (REG_WORDS)
	) i_reg_bank (
		.down    (down),
		.rst     (rst),
		.tgt_req (tgt_req),
		.tgt_rsp (tgt_rsp)
	);

endmodule

`default_nettype wire

/* tb/apb_wbuf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_wbuf_tb import apb_wbuf_pkg::*; ;

	localparam int FIFO_DEPTH  = 16;
	localparam int WAIT_CYCLES = 1;
	localparam int REG_WORDS   = 64;

	// Window spans four copies of the bank so addresses alias
	localparam int WINDOW_BYTES = REG_WORDS * 4 * 4;
	localparam int N_SPLIT      = 24;
	localparam int N_ROUND      = 6;
	localparam int ROUND_WR     = 4;
	localparam int N_MIX        = 400;

	// Each write is replayed as a pair, each read may wait behind a pair
	localparam int N_TRANS = 2 + 3 * N_SPLIT + N_ROUND * 3 * ROUND_WR
		+ 3 * FIFO_DEPTH + REG_WORDS + N_MIX;
	localparam int CYCLE_LIMIT = N_TRANS * (4 * (WAIT_CYCLES + 2) + 4) + 200;

	logic       down;
	logic       rst;
	apb64_req_t up_req;
	apb64_rsp_t up_rsp;

	integer seed = 32'h71505cb7;
	int     errors = 0;
	int     checks = 0;
	int     cycles = 0;
	int     max_stall = 0;

	// Reference copy of the register bank
	logic [31:0] model_mem [REG_WORDS];

	apb_wbuf_top #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.WAIT_CYCLES (WAIT_CYCLES),
		.REG_WORDS   (REG_WORDS)
	) i_dut (
		.down   (down),
		.rst    (rst),
		.up_req (up_req),
		.up_rsp (up_rsp)
	);

	//////////////////////////////
	// Clock and run limit
	//////////////////////////////

	initial down = 1'b0;
	always #4 down = ~down;

	always @(posedge down) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Bank word that a byte address lands on
	function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr);
		return (int'(addr) >> 2) % REG_WORDS;
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] rand_addr8();
		return ADDR_WIDTH'(({$random(seed)} % (WINDOW_BYTES / 8)) * 8);
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] rand_addr4();
		return ADDR_WIDTH'(({$random(seed)} % (WINDOW_BYTES / 4)) * 4);
	endfunction

	function automatic logic [63:0] rand_data64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	task automatic bus_idle();
		@(negedge down);
		up_req = '0;
	endtask

	// Setup then access, sampled well before the completing edge
	task automatic apb_access(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
		input logic [63:0] wdata, output logic [63:0] rdata, output logic slverr,
		output int stall);
		@(negedge down);
		up_req.psel    = 1'b1;
		up_req.penable = 1'b0;
		up_req.pwrite  = wr;
		up_req.paddr   = addr;
		up_req.pwdata  = wdata;
		@(negedge down);
		up_req.penable = 1'b1;
		stall = 0;
		#1;
		while (!up_rsp.pready) begin
			@(negedge down);
			#1;
			stall++;
		end
		rdata  = up_rsp.prdata;
		slverr = up_rsp.pslverr;
	endtask

	task automatic write64(input logic [ADDR_WIDTH-1:0] addr, input logic [63:0] data);
		logic [63:0] rdata;
		logic        slverr;
		int          stall;
		apb_access(1'b1, addr, data, rdata, slverr, stall);
		// No error response on writes either
		compare_value("up_rsp.pslverr", {63'h0, slverr}, 64'h0);
		if (stall > max_stall) begin
			max_stall = stall;
		end
		// Acknowledged, so the model commits now
		model_mem[word_index(addr)]                  = data[63:32];
		model_mem[word_index(addr + ADDR_WIDTH'(4))] = data[31:0];
	endtask

	task automatic read_check(input logic [ADDR_WIDTH-1:0] addr);
		logic [63:0] rdata;
		logic        slverr;
		int          stall;
		apb_access(1'b0, addr, '0, rdata, slverr, stall);
		compare_value("up_rsp.prdata", rdata, {32'h0, model_mem[word_index(addr)]});
		compare_value("up_rsp.pslverr", {63'h0, slverr}, 64'h0);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		logic [ADDR_WIDTH-1:0] addrs [ROUND_WR];
		logic [ADDR_WIDTH-1:0] a;
		up_req = '0;
		rst    = 1'b1;
		for (int i = 0; i < REG_WORDS; i++) begin
			model_mem[i] = '0;
		end
		repeat (2) @(negedge down);
		rst = 1'b0;

		// Reset state, no acknowledge while idle
		bus_idle();
		#1;
		compare_value("up_rsp.pready", {63'h0, up_rsp.pready}, 64'h0);
		read_check(rand_addr8());
		read_check(rand_addr4());

		// Each write read back as two halves
		for (int i = 0; i < N_SPLIT; i++) begin
			a = rand_addr8();
			write64(a, rand_data64());
			read_check(a);
			read_check(a + ADDR_WIDTH'(4));
		end

		// Writes straight into reads, no idle cycles
		for (int r = 0; r < N_ROUND; r++) begin
			for (int i = 0; i < ROUND_WR; i++) begin
				addrs[i] = rand_addr8();
				write64(addrs[i], rand_data64());
			end
			for (int i = 0; i < ROUND_WR; i++) begin
				read_check(addrs[i]);
				read_check(addrs[i] + ADDR_WIDTH'(4));
			end
		end

		// Burst that overruns the FIFO, then a full sweep
		bus_idle();
		max_stall = 0;
		for (int i = 0; i < 3 * FIFO_DEPTH; i++) begin
			write64(ADDR_WIDTH'(i * 8), rand_data64());
		end
		if (max_stall == 0) begin
			errors++;
			$display("Burst never filled the write buffer, back-pressure not exercised");
		end
		for (int i = 0; i < REG_WORDS; i++) begin
			read_check(ADDR_WIDTH'(i * 4));
		end

		// Random interleave with occasional idle gaps
		for (int i = 0; i < N_MIX; i++) begin
			if (({$random(seed)} % 4) == 0) begin
				bus_idle();
			end
			if ($random(seed) & 1) begin
				write64(rand_addr8(), rand_data64());
			end else begin
				read_check(rand_addr4());
			end
		end
		bus_idle();

		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
verilog/apb_wbuf_pkg.sv
verilog/apb_wbuf_fifo.sv
verilog/apb_wbuf_upstream.sv
verilog/apb_wbuf_splitter.sv
verilog/apb_reg_bank32.sv
verilog/apb_wbuf_top.sv
tb/apb_wbuf_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= apb_wbuf_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
